// File: flist.f
+incdir+include
logic/f8_pkg.sv
logic/mem_port_if.sv
logic/alu8.sv
logic/mem_banks.sv
logic/cycle_control.sv
logic/program_counter.sv
logic/execute_unit.sv
logic/f8_core.sv
tests/tb_clock.sv
tests/f8_core_tb.sv

// File: tests/f8_trace.txt
# p <byte address> <byte>   one program or data byte, loaded before reset ends
# w <byte address> <byte>   next expected write in program order, all fields hex
p 5000 19  p 5001 0f  p 5002 a6  p 5003 81  p 5004 3c  p 5005 c3  p 5006 7e
p 4000 90  p 4001 5a              # ld xl,#5a
p 4002 98  p 4003 00  p 4004 60   # ld 6000,xl
w 6000 5a
p 4005 98  p 4006 01  p 4007 60   # ld 6001,xl
w 6001 5a
p 4008 20  p 4009 37              # add xl,#37
p 400a 98  p 400b 02  p 400c 60
w 6002 91
p 400d 10  p 400e 21              # sub xl,#21
p 400f 98  p 4010 03  p 4011 60
w 6003 70
p 4012 40  p 4013 3c              # and xl,#3c
p 4014 98  p 4015 04  p 4016 60
w 6004 30
p 4017 38  p 4018 05              # or xl,#05
p 4019 98  p 401a 05  p 401b 60
w 6005 35
p 401c 48  p 401d ff              # xor xl,#ff
p 401e 98  p 401f 06  p 4020 60
w 6006 ca
p 4021 21  p 4022 00  p 4023 50   # add xl,5000
p 4024 98  p 4025 07  p 4026 60
w 6007 e3
p 4027 11  p 4028 01  p 4029 50   # sub xl,5001
p 402a 98  p 402b 08  p 402c 60
w 6008 d4
p 402d 41  p 402e 02  p 402f 50   # and xl,5002
p 4030 98  p 4031 09  p 4032 60
w 6009 84
p 4033 39  p 4034 03  p 4035 50   # or xl,5003
p 4036 98  p 4037 0a  p 4038 60
w 600a 85
p 4039 49  p 403a 04  p 403b 50   # xor xl,5004
p 403c 98  p 403d 0b  p 403e 60
w 600b b9
p 403f 91  p 4040 05  p 4041 50   # ld xl,5005 (odd source)
p 4042 98  p 4043 0c  p 4044 60
w 600c c3
p 4045 91  p 4046 06  p 4047 50   # ld xl,5006 (even source)
p 4048 98  p 4049 0d  p 404a 60
w 600d 7e
p 404b 20  p 404c 82              # add xl,#82 gives 00 with carry
p 404d d2  p 404e 05              # jrnz, not taken
p 404f 98  p 4050 0e  p 4051 60
w 600e 00
p 4052 d1  p 4053 05              # jrz, taken
p 4054 98  p 4055 0f  p 4056 60   # skipped
p 4057 d4  p 4058 05              # jrnc, not taken
p 4059 98  p 405a 10  p 405b 60
w 6010 00
p 405c 10  p 405d 01              # sub xl,#01 borrows, c clear
p 405e d3  p 405f 05              # jrc, not taken
p 4060 98  p 4061 11  p 4062 60
w 6011 ff
p 4063 d4  p 4064 05              # jrnc, taken
p 4065 98  p 4066 12  p 4067 60   # skipped
p 4068 10  p 4069 0f              # sub xl,#0f no borrow, c set
p 406a d1  p 406b 05              # jrz, not taken
p 406c 98  p 406d 13  p 406e 60
w 6013 f0
p 406f 48  p 4070 f0              # xor gives zero and keeps c
p 4071 d3  p 4072 05              # jrc, taken
p 4073 98  p 4074 14  p 4075 60   # skipped
p 4076 d2  p 4077 05              # jrnz, not taken
p 4078 98  p 4079 15  p 407a 60
w 6015 00
p 407b 90  p 407c 03              # ld xl,#03 loop count
p 407d 98  p 407e 21  p 407f 60   # loop body store
p 4080 10  p 4081 01              # sub xl,#01
p 4082 d1  p 4083 04              # jrz to trap
p 4084 d0  p 4085 f9              # jr back to the store
p 4086 00                         # trap
w 6021 03
w 6021 02
w 6021 01

// File: tests/f8_core_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// f8 core testbench
// banked memory model, trace driven write checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module f8_core_tb;

	localparam logic [15:0] reset_vector = 16'h4000;
	localparam integer hold_cycles = 20;
	localparam integer max_expected = 64;

	logic clk;
	logic reset;
	logic [14:0] mem_read_addr_even;
	logic [14:0] mem_read_addr_odd;
	logic [7:0] mem_read_data_even;
	logic [7:0] mem_read_data_odd;
	logic [14:0] mem_write_addr_even;
	logic [14:0] mem_write_addr_odd;
	logic [7:0] mem_write_data_even;
	logic [7:0] mem_write_data_odd;
	logic mem_write_en_even;
	logic mem_write_en_odd;
	logic trap;

	logic [7:0] bank_even [0:32767];
	logic [7:0] bank_odd [0:32767];
	logic [14:0] read_addr_even_q;
	logic [14:0] read_addr_odd_q;
	logic [15:0] exp_addr [0:max_expected-1];
	logic [7:0] exp_data [0:max_expected-1];
	integer exp_count;
	integer writes_seen;
	integer prog_bytes;
	integer cycles_after_reset;
	logic trace_loaded;

	tb_clock i_tb_clock
	(
		.clk(clk),
		.reset(reset)
	);

	f8_core i_f8_core
	(
		.clk(clk),
		.reset(reset),
		.mem_read_addr_even(mem_read_addr_even),
		.mem_read_addr_odd(mem_read_addr_odd),
		.mem_read_data_even(mem_read_data_even),
		.mem_read_data_odd(mem_read_data_odd),
		.mem_write_addr_even(mem_write_addr_even),
		.mem_write_addr_odd(mem_write_addr_odd),
		.mem_write_data_even(mem_write_data_even),
		.mem_write_data_odd(mem_write_data_odd),
		.mem_write_en_even(mem_write_en_even),
		.mem_write_en_odd(mem_write_en_odd),
		.trap(trap)
	);

	task fail_run;
		begin
			$display("Errors found");
			$fatal(1, "stopped at the first failure");
		end
	endtask

	task check_value(input logic [31:0] actual, input logic [31:0] expected, input string what);
		begin
			if (actual !== expected)
			begin
				$display("error at %0t: %s, expected %0h, got %0h", $time, what, expected, actual);
				fail_run;
			end
		end
	endtask

	function automatic logic [7:0] fill_byte(input logic [15:0] addr);
		fill_byte = addr[15:8] ^ addr[7:0];
	endfunction

	task fill_banks;
		integer i;
		logic [15:0] even_addr;
		begin
			for (i = 0; i < 32768; i = i + 1)
			begin
				even_addr = {i[14:0], 1'b0};
				bank_even[i] = fill_byte(even_addr);
				bank_odd[i] = fill_byte(even_addr | 16'h0001);
			end
		end
	endtask

	task store_byte(input logic [15:0] addr, input logic [7:0] data);
		begin
			if (addr[0])
				bank_odd[addr[15:1]] = data;
			else
				bank_even[addr[15:1]] = data;
		end
	endtask

	// records are a kind letter and two hex fields, # starts a comment
	task load_trace;
		integer fd;
		integer c;
		integer code;
		logic [15:0] addr;
		logic [7:0] data;
		begin
			fd = $fopen("tests/f8_trace.txt", "r");
			if (fd == 0)
			begin
				$display("cannot open the trace file tests/f8_trace.txt");
				fail_run;
			end
			c = $fgetc(fd);
			while (c != -1)
			begin
				if (c == "#")
				begin
					while (c != "\n" && c != -1)
						c = $fgetc(fd);
				end
				else if (c == "p" || c == "w")
				begin
					code = $fscanf(fd, "%h %h", addr, data);
					if (code != 2)
					begin
						$display("trace record with missing address or data");
						fail_run;
					end
					if (c == "p")
					begin
						store_byte(addr, data);
						prog_bytes = prog_bytes + 1;
					end
					else
					begin
						exp_addr[exp_count] = addr;
						exp_data[exp_count] = data;
						exp_count = exp_count + 1;
					end
				end
				else if (c != " " && c != "\n" && c != "\r" && c != "\t")
				begin
					$display("unknown record kind in the trace file");
					fail_run;
				end
				if (c != -1)
					c = $fgetc(fd);
			end
			$fclose(fd);
		end
	endtask

	task handle_write;
		logic [15:0] addr;
		logic [7:0] data;
		begin
			if (mem_write_en_even === 1'b1 && mem_write_en_odd === 1'b1)
			begin
				$display("both bank write enables are high in the same cycle");
				fail_run;
			end
			if (mem_write_en_odd === 1'b1)
			begin
				addr = {mem_write_addr_odd, 1'b1};
				data = mem_write_data_odd;
			end
			else
			begin
				addr = {mem_write_addr_even, 1'b0};
				data = mem_write_data_even;
			end
			if (writes_seen >= exp_count)
			begin
				$display("unexpected write of %h to address %h", data, addr);
				fail_run;
			end
			check_value(addr, exp_addr[writes_seen], "write address");
			check_value(data, exp_data[writes_seen], "write data");
			store_byte(addr, data);
			writes_seen = writes_seen + 1;
		end
	endtask

	// synchronous banks, data follows the address by one cycle
	always @(posedge clk)
	begin
		mem_read_data_even <= bank_even[read_addr_even_q];
		mem_read_data_odd <= bank_odd[read_addr_odd_q];
	end

	always @(negedge clk)
	begin
		read_addr_even_q = mem_read_addr_even;
		read_addr_odd_q = mem_read_addr_odd;
		if (cycles_after_reset == 0)
		begin
			check_value(mem_write_en_even, 1'b0, "even write enable around reset");
			check_value(mem_write_en_odd, 1'b0, "odd write enable around reset");
			check_value(trap, 1'b0, "trap around reset");
		end
		// vector is even, so both banks see the same word
		if (!reset && cycles_after_reset == 0)
		begin
			check_value(mem_read_addr_even, reset_vector[15:1], "even bank first fetch");
			check_value(mem_read_addr_odd, reset_vector[15:1], "odd bank first fetch");
		end
		if (mem_write_en_even === 1'b1 || mem_write_en_odd === 1'b1)
			handle_write;
		if (!reset)
			cycles_after_reset = cycles_after_reset + 1;
	end

	initial
	begin
		wait (trace_loaded === 1'b1);
		repeat (3 * prog_bytes + 20)
			@(posedge clk);
		$display("watchdog expired after %0d cycles without a finished run", 3 * prog_bytes + 20);
		fail_run;
	end

	initial
	begin
		trace_loaded = 1'b0;
		exp_count = 0;
		writes_seen = 0;
		prog_bytes = 0;
		cycles_after_reset = 0;
		mem_read_data_even = 8'h00;
		mem_read_data_odd = 8'h00;
		read_addr_even_q = reset_vector[15:1];
		read_addr_odd_q = reset_vector[15:1];
		fill_banks;
		load_trace;
		trace_loaded = 1'b1;
		while (trap !== 1'b1)
			@(negedge clk);
		check_value(writes_seen, exp_count, "number of writes when trap rose");
		repeat (hold_cycles)
		begin
			@(negedge clk);
			check_value(trap, 1'b1, "trap held after the halt");
		end
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset
// 100 ns clock, reset held for 4 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tb_clock
(
	output logic clk,
	output logic reset
);

	localparam integer half_period = 50;
	localparam integer reset_cycles = 4;

	initial
	begin
		clk = 1'b0;
		forever
			#half_period clk = ~clk;
	end

	initial
	begin
		reset = 1'b1;
		repeat (reset_cycles)
			@(posedge clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

// File: logic/f8_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reduced multi-cycle f8 core
// top level with even and odd bank memory ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module f8_core import f8_pkg::*;
(
	input wire clk,
	input wire reset,
	output bank_addr_t mem_read_addr_even,
	output bank_addr_t mem_read_addr_odd,
	input wire byte_t mem_read_data_even,
	input wire byte_t mem_read_data_odd,
	output bank_addr_t mem_write_addr_even,
	output bank_addr_t mem_write_addr_odd,
	output byte_t mem_write_data_even,
	output byte_t mem_write_data_odd,
	output logic mem_write_en_even,
	output logic mem_write_en_odd,
	output logic trap
);

	addr_t pc;
	addr_t next_pc;
	inst_t inst;
	byte_t operand;
	logic execute;
	logic branch_taken;

	mem_port_if mem_if ();

	mem_banks i_mem_banks
	(
		.clk(clk),
		.reset(reset),
		.mem(mem_if.banks),
		.mem_read_addr_even(mem_read_addr_even),
		.mem_read_addr_odd(mem_read_addr_odd),
		.mem_read_data_even(mem_read_data_even),
		.mem_read_data_odd(mem_read_data_odd),
		.mem_write_addr_even(mem_write_addr_even),
		.mem_write_addr_odd(mem_write_addr_odd),
		.mem_write_data_even(mem_write_data_even),
		.mem_write_data_odd(mem_write_data_odd),
		.mem_write_en_even(mem_write_en_even),
		.mem_write_en_odd(mem_write_en_odd)
	);

	cycle_control i_cycle_control
	(
		.clk(clk),
		.reset(reset),
		.mem(mem_if.core),
		.pc(pc),
		.next_pc(next_pc),
		.inst(inst),
		.operand(operand),
		.execute(execute),
		.trap(trap)
	);

	program_counter i_program_counter
	(
		.clk(clk),
		.reset(reset),
		.execute(execute),
		.inst(inst),
		.branch_taken(branch_taken),
		.pc(pc),
		.next_pc(next_pc)
	);

	execute_unit i_execute_unit
	(
		.clk(clk),
		.reset(reset),
		.mem(mem_if.core),
		.execute(execute),
		.inst(inst),
		.operand(operand),
		.branch_taken(branch_taken)
	);

endmodule

`default_nettype wire

// File: logic/execute_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// f8 execute unit
// accumulator, flags, jump conditions and stores
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "f8_defines.svh"

module execute_unit import f8_pkg::*;
(
	input wire clk,
	input wire reset,
	mem_port_if.core mem,
	input wire execute,
	input wire inst_t inst,
	input wire byte_t operand,
	output logic branch_taken
);

	byte_t xl;
	flags_t flags;
	byte_t opcode;
	byte_t alu_result;
	flags_t alu_flags;

	assign opcode = inst[7:0];

	alu8 i_alu8
	(
		.op(opcode),
		.acc(xl),
		.operand(operand),
		.result(alu_result),
		.flags_in(flags),
		.flags_out(alu_flags)
	);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			xl <= '0;
			flags <= '0;
		end
		else if (execute)
		begin
			case (opcode)
				`F8_OP_ADD_XL_IMMD, `F8_OP_ADD_XL_DIR, `F8_OP_SUB_XL_IMMD, `F8_OP_SUB_XL_DIR,
				`F8_OP_AND_XL_IMMD, `F8_OP_AND_XL_DIR, `F8_OP_OR_XL_IMMD, `F8_OP_OR_XL_DIR,
				`F8_OP_XOR_XL_IMMD, `F8_OP_XOR_XL_DIR:
				begin
					xl <= alu_result;
					flags <= alu_flags;
				end
				`F8_OP_LD_XL_IMMD:
					xl <= operand;
				// memory loads also test the byte
				`F8_OP_LD_XL_DIR:
				begin
					xl <= operand;
					flags[`F8_FLAG_Z] <= (operand == '0);
					flags[`F8_FLAG_N] <= operand[7];
				end
				default:
					xl <= xl;
			endcase
		end
	end

	always_comb
	begin
		case (opcode)
			`F8_OP_JR_D:
				branch_taken = 1'b1;
			`F8_OP_JRZ_D:
				branch_taken = flags[`F8_FLAG_Z];
			`F8_OP_JRNZ_D:
				branch_taken = !flags[`F8_FLAG_Z];
			`F8_OP_JRC_D:
				branch_taken = flags[`F8_FLAG_C];
			`F8_OP_JRNC_D:
				branch_taken = !flags[`F8_FLAG_C];
			default:
				branch_taken = 1'b0;
		endcase
	end

	// one cycle store strobe for ld dir,xl
	assign mem.write_en = execute && (opcode == `F8_OP_LD_DIR_XL);
	assign mem.write_addr = inst[23:8];
	assign mem.write_data = xl;

endmodule

`default_nettype wire

// File: logic/program_counter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// f8 program counter
// steps by instruction size or relative jump
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "f8_defines.svh"

module program_counter import f8_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire execute,
	input wire inst_t inst,
	input wire branch_taken,
	output addr_t pc,
	output addr_t next_pc
);

	byte_t opcode;
	byte_t disp;

	function automatic addr_t inst_size(byte_t op);
		if (op_is_dir(op))
			return addr_t'(`F8_INST_SIZE_DIR);
		case (op)
			`F8_OP_LD_XL_IMMD, `F8_OP_ADD_XL_IMMD, `F8_OP_SUB_XL_IMMD, `F8_OP_AND_XL_IMMD,
			`F8_OP_OR_XL_IMMD, `F8_OP_XOR_XL_IMMD, `F8_OP_JR_D, `F8_OP_JRZ_D,
			`F8_OP_JRNZ_D, `F8_OP_JRC_D, `F8_OP_JRNC_D:
				return addr_t'(`F8_INST_SIZE_IMMD);
			default:
				return addr_t'(`F8_INST_SIZE_SHORT);
		endcase
	endfunction

	assign opcode = inst[7:0];
	assign disp = inst[15:8];

	always_comb
	begin
		if (!execute)
			next_pc = pc;
		else if (branch_taken)
			// relative to the jump opcode itself
			next_pc = pc + {{(`F8_ADDR_W-`F8_DATA_W){disp[7]}}, disp};
		else
			next_pc = pc + inst_size(opcode);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= `F8_RESET_VECTOR;
		else if (execute)
			pc <= next_pc;
	end

endmodule

`default_nettype wire

// File: logic/cycle_control.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// f8 cycle control
// sequences fetch, upper byte and operand cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "f8_defines.svh"

module cycle_control import f8_pkg::*;
(
	input wire clk,
	input wire reset,
	mem_port_if.core mem,
	input wire addr_t pc,
	input wire addr_t next_pc,
	output inst_t inst,
	output byte_t operand,
	output logic execute,
	output logic trap
);

	cycle_state_t state;
	cycle_state_t state_next;
	logic started;
	inst_t inst_q;
	byte_t opcode;

	function automatic logic loads_operand(byte_t op);
		return op_is_dir(op) && op != `F8_OP_LD_DIR_XL;
	endfunction

	// instruction bytes as far as they have arrived
	always_comb
	begin
		case (state)
			CYC_UPPER:
				inst = {mem.read_data[15:8], inst_q[15:0]};
			CYC_OPERAND, CYC_HALT:
				inst = inst_q;
			default:
				inst = {8'h00, mem.read_data};
		endcase
	end

	assign opcode = inst[7:0];
	// immediate follows the opcode, memory operand is the low byte
	assign operand = (state == CYC_OPERAND) ? mem.read_data[7:0] : mem.read_data[15:8];

	always_comb
	begin
		state_next = state;
		execute = 1'b0;
		trap = 1'b0;
		mem.read_addr = next_pc;
		case (state)
			CYC_FETCH:
				if (started)
				begin
					if (opcode == `F8_OP_TRAP)
					begin
						trap = 1'b1;
						state_next = CYC_HALT;
					end
					else if (op_is_dir(opcode))
					begin
						mem.read_addr = pc + 1'b1;
						state_next = CYC_UPPER;
					end
					else
						execute = 1'b1;
				end
			CYC_UPPER:
				if (loads_operand(opcode))
				begin
					mem.read_addr = inst[23:8];
					state_next = CYC_OPERAND;
				end
				else
				begin
					execute = 1'b1;
					state_next = CYC_FETCH;
				end
			CYC_OPERAND:
			begin
				execute = 1'b1;
				state_next = CYC_FETCH;
			end
			default:
				trap = 1'b1;
		endcase
	end

	// first cycle after reset only waits for the vector fetch
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= CYC_FETCH;
			started <= 1'b0;
		end
		else
		begin
			state <= state_next;
			started <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == CYC_FETCH)
			inst_q[15:0] <= mem.read_data;
		if (state == CYC_UPPER)
			inst_q[23:16] <= mem.read_data[15:8];
	end

endmodule

`default_nettype wire

// File: logic/mem_banks.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// even/odd bank steering
// maps byte addresses onto two byte wide banks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "f8_defines.svh"

module mem_banks import f8_pkg::*;
(
	input wire clk,
	input wire reset,
	mem_port_if.banks mem,
	output bank_addr_t mem_read_addr_even,
	output bank_addr_t mem_read_addr_odd,
	input wire byte_t mem_read_data_even,
	input wire byte_t mem_read_data_odd,
	output bank_addr_t mem_write_addr_even,
	output bank_addr_t mem_write_addr_odd,
	output byte_t mem_write_data_even,
	output byte_t mem_write_data_odd,
	output logic mem_write_en_even,
	output logic mem_write_en_odd
);

	bank_addr_t read_word;
	bank_addr_t write_word;
	logic read_odd_q;

	assign read_word = mem.read_addr[`F8_ADDR_W-1:1];
	assign write_word = mem.write_addr[`F8_ADDR_W-1:1];

	// odd start address, the second byte sits in the next even word
	assign mem_read_addr_even = mem.read_addr[0] ? read_word + 1'b1 : read_word;
	assign mem_read_addr_odd = read_word;

	always_ff @(posedge clk)
	begin
		if (reset)
			read_odd_q <= 1'b0;
		else
			read_odd_q <= mem.read_addr[0];
	end

	assign mem.read_data = read_odd_q ? {mem_read_data_even, mem_read_data_odd}
		: {mem_read_data_odd, mem_read_data_even};

	// byte writes only hit the bank of matching parity
	assign mem_write_addr_even = write_word;
	assign mem_write_addr_odd = write_word;
	assign mem_write_data_even = mem.write_data;
	assign mem_write_data_odd = mem.write_data;
	assign mem_write_en_even = mem.write_en && !mem.write_addr[0];
	assign mem_write_en_odd = mem.write_en && mem.write_addr[0];

endmodule

`default_nettype wire

// File: logic/alu8.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// f8 8-bit alu
// add, sub and logic ops with flag results
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "f8_defines.svh"

module alu8 import f8_pkg::*;
(
	input wire byte_t op,
	input wire byte_t acc,
	input wire byte_t operand,
	output byte_t result,
	input wire flags_t flags_in,
	output flags_t flags_out
);

	logic subtract;
	byte_t addend;
	logic [`F8_DATA_W:0] sum;
	logic [4:0] half_sum;
	logic overflow;

	// sub is acc + ~operand + 1, so carry set means no borrow
	assign subtract = (op == `F8_OP_SUB_XL_IMMD) || (op == `F8_OP_SUB_XL_DIR);
	assign addend = subtract ? ~operand : operand;
	assign sum = {1'b0, acc} + {1'b0, addend} + {8'h00, subtract};
	assign half_sum = {1'b0, acc[3:0]} + {1'b0, addend[3:0]} + {4'h0, subtract};
	assign overflow = (acc[7] == addend[7]) && (sum[7] != acc[7]);

	always_comb
	begin
		logic update_zn;
		update_zn = 1'b1;
		result = acc;
		flags_out = flags_in;
		case (op)
			`F8_OP_ADD_XL_IMMD, `F8_OP_ADD_XL_DIR, `F8_OP_SUB_XL_IMMD, `F8_OP_SUB_XL_DIR:
			begin
				result = sum[7:0];
				flags_out[`F8_FLAG_H] = half_sum[4];
				flags_out[`F8_FLAG_C] = sum[8];
				flags_out[`F8_FLAG_O] = overflow;
			end
			`F8_OP_AND_XL_IMMD, `F8_OP_AND_XL_DIR:
				result = acc & operand;
			`F8_OP_OR_XL_IMMD, `F8_OP_OR_XL_DIR:
				result = acc | operand;
			`F8_OP_XOR_XL_IMMD, `F8_OP_XOR_XL_DIR:
				result = acc ^ operand;
			default:
				update_zn = 1'b0;
		endcase
		if (update_zn)
		begin
			flags_out[`F8_FLAG_Z] = (result == '0);
			flags_out[`F8_FLAG_N] = result[7];
		end
	end

endmodule

`default_nettype wire

// File: logic/mem_port_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// core to bank unit memory port
// byte address reads of two bytes, byte writes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

interface mem_port_if import f8_pkg::*; ();

	addr_t read_addr;
	// byte at the registered address low, next byte high
	word_t read_data;
	addr_t write_addr;
	byte_t write_data;
	logic write_en;

	modport core
	(
		output read_addr,
		input read_data,
		output write_addr,
		output write_data,
		output write_en
	);

	modport banks
	(
		input read_addr,
		output read_data,
		input write_addr,
		input write_data,
		input write_en
	);

endinterface

`default_nettype wire

// File: logic/f8_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// f8 core types
// vector types, cycle states, direct form decode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "f8_defines.svh"

package f8_pkg;

	typedef logic [`F8_DATA_W-1:0] byte_t;
	typedef logic [`F8_ADDR_W-1:0] addr_t;
	typedef logic [`F8_BANK_ADDR_W-1:0] bank_addr_t;
	typedef logic [2*`F8_DATA_W-1:0] word_t;
	// opcode in the low byte, operand bytes above
	typedef logic [3*`F8_DATA_W-1:0] inst_t;
	typedef logic [`F8_FLAGS_W-1:0] flags_t;

	typedef enum logic [1:0]
	{
		CYC_FETCH,
		CYC_UPPER,
		CYC_OPERAND,
		CYC_HALT
	} cycle_state_t;

	// three byte forms with a direct address
	function automatic logic op_is_dir(byte_t op);
		case (op)
			`F8_OP_LD_XL_DIR, `F8_OP_LD_DIR_XL, `F8_OP_ADD_XL_DIR, `F8_OP_SUB_XL_DIR,
			`F8_OP_AND_XL_DIR, `F8_OP_OR_XL_DIR, `F8_OP_XOR_XL_DIR:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

endpackage

`default_nettype wire

// File: include/f8_defines.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// f8 core constants
// widths, reset vector, opcodes, sizes, flag bits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef F8_DEFINES_SVH
`define F8_DEFINES_SVH

`define F8_ADDR_W 16
`define F8_BANK_ADDR_W 15
`define F8_DATA_W 8
`define F8_FLAGS_W 5

`define F8_RESET_VECTOR 16'h4000

`define F8_INST_SIZE_SHORT 1
`define F8_INST_SIZE_IMMD 2
`define F8_INST_SIZE_DIR 3

`define F8_OP_TRAP 8'h00
`define F8_OP_NOP 8'h08
`define F8_OP_SUB_XL_IMMD 8'h10
`define F8_OP_SUB_XL_DIR 8'h11
`define F8_OP_ADD_XL_IMMD 8'h20
`define F8_OP_ADD_XL_DIR 8'h21
`define F8_OP_OR_XL_IMMD 8'h38
`define F8_OP_OR_XL_DIR 8'h39
`define F8_OP_AND_XL_IMMD 8'h40
`define F8_OP_AND_XL_DIR 8'h41
`define F8_OP_XOR_XL_IMMD 8'h48
`define F8_OP_XOR_XL_DIR 8'h49
`define F8_OP_LD_XL_IMMD 8'h90
`define F8_OP_LD_XL_DIR 8'h91
`define F8_OP_LD_DIR_XL 8'h98
`define F8_OP_JR_D 8'hd0
`define F8_OP_JRZ_D 8'hd1
`define F8_OP_JRNZ_D 8'hd2
`define F8_OP_JRC_D 8'hd3
`define F8_OP_JRNC_D 8'hd4

// bit positions in flags_t
`define F8_FLAG_H 0
`define F8_FLAG_C 1
`define F8_FLAG_N 2
`define F8_FLAG_Z 3
`define F8_FLAG_O 4

`endif
